// ==== hw/isa_pkg.sv ====
package isa_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_addr_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_t;

    // Register group, selected by the low six bits
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_t;

    ////////////////////
    // Field positions
    localparam int OPCODE_MSB = 15;
    localparam int RS_LSB     = 10;
    localparam int RT_LSB     = 8;
    localparam int RD_LSB     = 6;
    localparam int IMM_WIDTH  = 8;

    // ORI r0, r0, 0
    localparam word_t NOP_INST = {OP_ORI, 12'h000};

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LHI
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_src_e;

endpackage

// ==== hw/pipeline_control.sv ====
`timescale 1ns/100ps

module pipeline_control (
    input  logic                clk,
    input  logic                reset_n,
    input  isa_pkg::word_t      inst,
    input  logic                inst_valid,
    input  logic                ex_mem_read,
    input  isa_pkg::reg_addr_t  ex_dest,
    input  logic                redirect,
    output logic                stall,
    output logic                freeze,
    output pipe_pkg::alu_op_e   alu_op,
    output logic                use_imm,
    output logic                mem_read,
    output logic                mem_write,
    output logic                reg_write,
    output pipe_pkg::wb_src_e   wb_src,
    output logic                is_wwd,
    output logic                is_halt,
    output logic                is_branch_eq,
    output logic                is_branch_ne,
    output logic                is_jump,
    output isa_pkg::reg_addr_t  dest,
    output logic                id_valid,
    output pipe_pkg::fwd_sel_e  fwd_a,
    output pipe_pkg::fwd_sel_e  fwd_b,
    input  isa_pkg::reg_addr_t  mem_dest,
    input  isa_pkg::reg_addr_t  wb_dest,
    input  logic                mem_reg_write,
    input  logic                wb_reg_write
);
    import isa_pkg::*;
    import pipe_pkg::*;

    typedef enum logic {RUN, HALTED} halt_state_e;

    halt_state_e state;
    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rs, rt, ex_rs, ex_rt;
    logic        hazard, halt_now;

    assign opcode = opcode_t'(inst[OPCODE_MSB -: 4]);
    assign funct  = funct_t'(inst[5:0]);
    assign rs     = inst[RS_LSB +: 2];
    assign rt     = inst[RT_LSB +: 2];

    always_comb begin
        alu_op       = ALU_ADD;
        use_imm      = 1'b1;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        reg_write    = 1'b0;
        wb_src       = WB_ALU;
        is_wwd       = 1'b0;
        is_halt      = 1'b0;
        is_branch_eq = 1'b0;
        is_branch_ne = 1'b0;
        is_jump      = 1'b0;
        dest         = rt;                  // I-type writes rt
        case (opcode)
            OP_ADI: reg_write = 1'b1;
            OP_ORI: begin
                alu_op    = ALU_OR;
                reg_write = 1'b1;
            end
            OP_LHI: begin
                alu_op    = ALU_LHI;
                reg_write = 1'b1;
            end
            OP_LWD: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
                wb_src    = WB_MEM;
            end
            OP_SWD: mem_write = 1'b1;
            OP_BEQ: is_branch_eq = 1'b1;
            OP_BNE: is_branch_ne = 1'b1;
            OP_JMP: is_jump = 1'b1;
            OP_RTYPE: begin
                use_imm = 1'b0;
                dest    = inst[RD_LSB +: 2];
                case (funct)
                    FN_ADD: reg_write = 1'b1;
                    FN_SUB: begin
                        alu_op    = ALU_SUB;
                        reg_write = 1'b1;
                    end
                    FN_AND: begin
                        alu_op    = ALU_AND;
                        reg_write = 1'b1;
                    end
                    FN_ORR: begin
                        alu_op    = ALU_OR;
                        reg_write = 1'b1;
                    end
                    FN_WWD: is_wwd = 1'b1;
                    FN_HLT: is_halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Load in execute feeding the instruction in decode
    assign hazard   = inst_valid && ex_mem_read && (ex_dest == rs || ex_dest == rt);
    assign stall    = hazard && !redirect && state == RUN;
    assign halt_now = inst_valid && is_halt && !hazard && !redirect && state == RUN;
    assign freeze   = halt_now || state == HALTED;
    assign id_valid = inst_valid && !hazard && !redirect && state == RUN;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= RUN;
            ex_rs <= '0;
            ex_rt <= '0;
        end else begin
            if (halt_now)
                state <= HALTED;
            ex_rs <= rs;    // sources of the instruction entering execute
            ex_rt <= rt;
        end
    end

    // Memory stage wins over writeback
    always_comb begin
        fwd_a = FWD_REG;
        fwd_b = FWD_REG;
        if (mem_reg_write && mem_dest == ex_rs)
            fwd_a = FWD_MEM;
        else if (wb_reg_write && wb_dest == ex_rs)
            fwd_a = FWD_WB;
        if (mem_reg_write && mem_dest == ex_rt)
            fwd_b = FWD_MEM;
        else if (wb_reg_write && wb_dest == ex_rt)
            fwd_b = FWD_WB;
    end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           stall,
    input  logic           freeze,
    input  logic           redirect,
    input  isa_pkg::word_t redirect_pc,
    output isa_pkg::word_t imem_addr,
    input  isa_pkg::word_t imem_data,
    output isa_pkg::word_t inst,
    output isa_pkg::word_t inst_pc,
    output logic           inst_valid
);
    import isa_pkg::*;

    word_t pc;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc         <= '0;
            inst       <= NOP_INST;
            inst_pc    <= '0;
            inst_valid <= 1'b0;
        end else if (redirect) begin
            pc         <= redirect_pc;
            inst       <= NOP_INST;     // squash wrong-path fetch
            inst_valid <= 1'b0;
        end else if (freeze) begin
            inst       <= NOP_INST;
            inst_valid <= 1'b0;
        end else if (!stall) begin
            pc         <= pc + 16'd1;  // always predict PC+1
            inst       <= imem_data;
            inst_pc    <= pc;
            inst_valid <= 1'b1;
        end
    end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/100ps

module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  isa_pkg::reg_addr_t rs,
    input  isa_pkg::reg_addr_t rt,
    output isa_pkg::word_t     rs_data,
    output isa_pkg::word_t     rt_data,
    input  isa_pkg::reg_addr_t wb_dest,
    input  logic               wb_reg_write,
    input  isa_pkg::word_t     wb_value
);
    import isa_pkg::*;

    word_t regs [4];

    // Write-through on a same-cycle read
    assign rs_data = (wb_reg_write && wb_dest == rs) ? wb_value : regs[rs];
    assign rt_data = (wb_reg_write && wb_dest == rt) ? wb_value : regs[rt];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end else if (wb_reg_write) begin
            regs[wb_dest] <= wb_value;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  pipe_pkg::alu_op_e   alu_op,
    input  logic                use_imm,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                reg_write,
    input  pipe_pkg::wb_src_e   wb_src,
    input  logic                is_wwd,
    input  logic                is_halt,
    input  logic                is_branch_eq,
    input  logic                is_branch_ne,
    input  logic                is_jump,
    input  isa_pkg::reg_addr_t  dest,
    input  logic                id_valid,
    input  isa_pkg::word_t      rs_data,
    input  isa_pkg::word_t      rt_data,
    input  isa_pkg::word_t      inst,
    input  isa_pkg::word_t      inst_pc,
    input  pipe_pkg::fwd_sel_e  fwd_a,
    input  pipe_pkg::fwd_sel_e  fwd_b,
    input  isa_pkg::word_t      mem_alu,
    input  isa_pkg::word_t      wb_value,
    output isa_pkg::word_t      ex_alu,
    output isa_pkg::word_t      ex_store,
    output isa_pkg::reg_addr_t  ex_dest,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output pipe_pkg::wb_src_e   ex_wb_src,
    output logic                ex_is_wwd,
    output logic                ex_is_halt,
    output logic                ex_valid,
    output logic                redirect,
    output isa_pkg::word_t      redirect_pc
);
    import isa_pkg::*;
    import pipe_pkg::*;

    ////////////////////
    // ID/EX registers
    alu_op_e op_q;
    wb_src_e wb_src_q;
    logic    use_imm_q, mem_read_q, mem_write_q, reg_write_q, wwd_q, halt_q;
    logic    beq_q, bne_q, jump_q, valid_q;
    word_t   rs_q, rt_q, inst_q, pc_q;
    word_t   a, b_reg, b, imm_ext, alu_res;
    logic    taken;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= id_valid;     // bubble on stall or squash
        end
    end

    always_ff @(posedge clk) begin
        op_q        <= alu_op;
        wb_src_q    <= wb_src;
        use_imm_q   <= use_imm;
        mem_read_q  <= mem_read;
        mem_write_q <= mem_write;
        reg_write_q <= reg_write;
        wwd_q       <= is_wwd;
        halt_q      <= is_halt;
        beq_q       <= is_branch_eq;
        bne_q       <= is_branch_ne;
        jump_q      <= is_jump;
        ex_dest     <= dest;
        rs_q        <= rs_data;
        rt_q        <= rt_data;
        inst_q      <= inst;
        pc_q        <= inst_pc;
    end

    always_comb begin
        case (fwd_a)
            FWD_MEM: a = mem_alu;
            FWD_WB:  a = wb_value;
            default: a = rs_q;
        endcase
        case (fwd_b)
            FWD_MEM: b_reg = mem_alu;
            FWD_WB:  b_reg = wb_value;
            default: b_reg = rt_q;
        endcase
    end

    // ORI zero-extends, everything else sign-extends
    assign imm_ext = (op_q == ALU_OR) ? {8'h00, inst_q[IMM_WIDTH-1:0]}
                                      : {{8{inst_q[IMM_WIDTH-1]}}, inst_q[IMM_WIDTH-1:0]};
    assign b = use_imm_q ? imm_ext : b_reg;

    always_comb begin
        case (op_q)
            ALU_SUB: alu_res = a - b;
            ALU_AND: alu_res = a & b;
            ALU_OR:  alu_res = a | b;
            ALU_LHI: alu_res = {inst_q[IMM_WIDTH-1:0], 8'h00};
            default: alu_res = a + b;
        endcase
    end

    assign ex_alu       = wwd_q ? a : alu_res;   // WWD carries rs
    assign ex_store     = b_reg;
    assign ex_valid     = valid_q;
    assign ex_reg_write = valid_q && reg_write_q;
    assign ex_mem_read  = valid_q && mem_read_q;
    assign ex_mem_write = valid_q && mem_write_q;
    assign ex_wb_src    = wb_src_q;
    assign ex_is_wwd    = valid_q && wwd_q;
    assign ex_is_halt   = valid_q && halt_q;

    ////////////////////
    // Branch and jump
    assign taken       = (beq_q && a == b_reg) || (bne_q && a != b_reg);
    assign redirect    = valid_q && (taken || jump_q);
    assign redirect_pc = jump_q ? {pc_q[15:12], inst_q[11:0]}
                                : pc_q + 16'd1 + imm_ext;

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic               clk,
    input  logic               reset_n,
    input  isa_pkg::word_t     ex_alu,
    input  isa_pkg::word_t     ex_store,
    input  isa_pkg::reg_addr_t ex_dest,
    input  logic               ex_reg_write,
    input  logic               ex_mem_read,
    input  logic               ex_mem_write,
    input  pipe_pkg::wb_src_e  ex_wb_src,
    input  logic               ex_is_wwd,
    input  logic               ex_is_halt,
    input  logic               ex_valid,
    output isa_pkg::reg_addr_t mem_dest,
    output logic               mem_reg_write,
    output isa_pkg::word_t     mem_alu,
    output isa_pkg::reg_addr_t wb_dest,
    output logic               wb_reg_write,
    output isa_pkg::word_t     wb_value,
    output isa_pkg::word_t     output_port,
    output logic               output_valid,
    output isa_pkg::word_t     num_inst,
    output logic               is_halted
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);

    word_t   dmem [DMEM_DEPTH];
    word_t   store_q, rdata_q, wb_alu_q;
    wb_src_e mem_src_q, wb_src_q;
    logic    mem_read_q, mem_write_q, mem_wwd_q, mem_halt_q, mem_valid_q;
    logic    wb_wwd_q, wb_halt_q, wb_valid_q;

    initial begin
        for (int i = 0; i < DMEM_DEPTH; i++)
            dmem[i] = '0;
    end

    ////////////////////
    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_valid_q   <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_read_q    <= 1'b0;
            mem_write_q   <= 1'b0;
            mem_wwd_q     <= 1'b0;
            mem_halt_q    <= 1'b0;
        end else begin
            mem_valid_q   <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_read_q    <= ex_mem_read;
            mem_write_q   <= ex_mem_write;
            mem_wwd_q     <= ex_is_wwd;
            mem_halt_q    <= ex_is_halt;
        end
        mem_alu   <= ex_alu;
        store_q   <= ex_store;
        mem_dest  <= ex_dest;
        mem_src_q <= ex_wb_src;
    end

    // Data RAM, low address bits only
    always_ff @(posedge clk) begin
        if (mem_write_q)
            dmem[mem_alu[AW-1:0]] <= store_q;
        if (mem_read_q)
            rdata_q <= dmem[mem_alu[AW-1:0]];
    end

    ////////////////////
    // MEM/WB and retire
    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_valid_q   <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_wwd_q     <= 1'b0;
            wb_halt_q    <= 1'b0;
            num_inst     <= '0;
            is_halted    <= 1'b0;
        end else begin
            wb_valid_q   <= mem_valid_q;
            wb_reg_write <= mem_reg_write;
            wb_wwd_q     <= mem_wwd_q;
            wb_halt_q    <= mem_halt_q;
            if (wb_valid_q)
                num_inst <= num_inst + 16'd1;
            if (wb_halt_q)
                is_halted <= 1'b1;   // sticky until reset
        end
        wb_alu_q <= mem_alu;
        wb_dest  <= mem_dest;
        wb_src_q <= mem_src_q;
    end

    assign wb_value     = (wb_src_q == WB_MEM) ? rdata_q : wb_alu_q;
    assign output_port  = wb_alu_q;
    assign output_valid = wb_wwd_q;

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic           clk,
    input  logic           reset_n,
    output isa_pkg::word_t imem_addr,
    input  isa_pkg::word_t imem_data,
    output isa_pkg::word_t output_port,
    output logic           output_valid,
    output isa_pkg::word_t num_inst,
    output logic           is_halted
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t     inst, inst_pc, redirect_pc, rs_data, rt_data;
    word_t     mem_alu, wb_value, ex_alu, ex_store;
    logic      inst_valid, stall, freeze, redirect;
    reg_addr_t dest, ex_dest, mem_dest, wb_dest;
    logic      mem_reg_write, wb_reg_write;
    fwd_sel_e  fwd_a, fwd_b;

    // Decoded controls
    alu_op_e   alu_op;
    wb_src_e   wb_src, ex_wb_src;
    logic      use_imm, mem_read, mem_write, reg_write, is_wwd, is_halt;
    logic      is_branch_eq, is_branch_ne, is_jump, id_valid;

    // Execute outputs
    logic      ex_reg_write, ex_mem_read, ex_mem_write, ex_is_wwd, ex_is_halt, ex_valid;

    pipeline_control u_control (
        .clk, .reset_n, .inst, .inst_valid, .ex_mem_read, .ex_dest, .redirect,
        .stall, .freeze, .alu_op, .use_imm, .mem_read, .mem_write, .reg_write,
        .wb_src, .is_wwd, .is_halt, .is_branch_eq, .is_branch_ne, .is_jump,
        .dest, .id_valid, .fwd_a, .fwd_b,
        .mem_dest, .wb_dest, .mem_reg_write, .wb_reg_write
    );

    fetch_stage u_fetch (
        .clk, .reset_n, .stall, .freeze, .redirect, .redirect_pc,
        .imem_addr, .imem_data, .inst, .inst_pc, .inst_valid
    );

    register_file u_regs (
        .clk, .reset_n,
        .rs(inst[RS_LSB +: 2]), .rt(inst[RT_LSB +: 2]),
        .rs_data, .rt_data, .wb_dest, .wb_reg_write, .wb_value
    );

    execute_stage u_execute (
        .clk, .reset_n, .alu_op, .use_imm, .mem_read, .mem_write, .reg_write,
        .wb_src, .is_wwd, .is_halt, .is_branch_eq, .is_branch_ne, .is_jump,
        .dest, .id_valid, .rs_data, .rt_data, .inst, .inst_pc, .fwd_a, .fwd_b,
        .mem_alu, .wb_value, .ex_alu, .ex_store, .ex_dest, .ex_reg_write,
        .ex_mem_read, .ex_mem_write, .ex_wb_src, .ex_is_wwd, .ex_is_halt,
        .ex_valid, .redirect, .redirect_pc
    );

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .clk, .reset_n, .ex_alu, .ex_store, .ex_dest, .ex_reg_write,
        .ex_mem_read, .ex_mem_write, .ex_wb_src, .ex_is_wwd, .ex_is_halt,
        .ex_valid, .mem_dest, .mem_reg_write, .mem_alu,
        .wb_dest, .wb_reg_write, .wb_value,
        .output_port, .output_valid, .num_inst, .is_halted
    );

endmodule

// ==== tb/cpu_sva.sv ====
`timescale 1ns/100ps

module cpu_sva (
    input logic           clk,
    input logic           reset_n,
    input isa_pkg::word_t imem_addr,
    input logic           output_valid,
    input logic           is_halted
);
    int failures = 0;

    // Halt is sticky until the next reset
    halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted)
        else begin
            $error("is_halted fell while out of reset");
            failures++;
        end

    no_output_after_halt: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> !output_valid)
        else begin
            $error("output_valid rose after the core had halted");
            failures++;
        end

    fetch_frozen: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> $stable(imem_addr))
        else begin
            $error("imem_addr moved while halted");
            failures++;
        end

endmodule

bind cpu_top cpu_sva u_sva (.clk, .reset_n, .imem_addr, .output_valid, .is_halted);

// ==== tb/tb_cpu_model.svh ====
localparam word_t HLT_WORD = {OP_RTYPE, 6'd0, FN_HLT};

word_t prog       [PROG_SIZE];
word_t model_regs [4];
word_t model_dmem [DMEM_DEPTH];    // not cleared between tests, same as the DUT RAM
word_t model_out  [$];
int    model_count;

function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % unsigned'(hi - lo + 1));
endfunction

function automatic word_t enc_r(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
    return {OP_RTYPE, rs, rt, rd, fn};
endfunction

function automatic word_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rt, logic [7:0] imm);
    return {op, rs, rt, imm};
endfunction

////////////////////
// Program generator
// Kinds 0-3 ADD SUB AND ORR, 4-6 ADI ORI LHI, 7 LWD, 8 SWD, 9 BEQ, 10 BNE, 11 JMP, 12 WWD
function automatic word_t random_inst(int addr, int len, int mode);
    int         kind;
    int         r;
    int         hi;
    int         target;
    reg_addr_t  rs, rt, rd;
    logic [7:0] imm;
    r = rand_range(0, 8);
    case (mode)
        0: kind = (r >= 7) ? 12 : r;
        1: kind = (r < 2) ? 7 : (r < 4) ? 8 : (r == 4) ? 4 : (r == 5) ? 1 : 12;
        2: kind = (r < 2) ? 9 : (r < 4) ? 10 : (r == 4) ? 11 : (r == 5) ? 4 : (r == 6) ? 0 : 12;
        default: kind = rand_range(0, 12);
    endcase
    hi     = (mode == 1 || mode == 3) ? 2 : 3;   // r3 stays zero as the memory base
    rs     = reg_addr_t'(rand_range(0, 3));
    rt     = reg_addr_t'(rand_range(0, hi));
    rd     = reg_addr_t'(rand_range(0, hi));
    imm    = 8'(rand_range(0, 255));
    target = rand_range(addr + 1, (addr + 5 < len - 1) ? addr + 5 : len - 1);
    if (kind == 7 || kind == 8) begin
        rs  = 2'd3;
        imm = 8'(rand_range(0, 7));
    end else if (mode == 2 && kind == 4) begin
        imm = 8'(rand_range(0, 2));    // keeps registers close so BEQ gets taken
    end
    case (kind)
        0, 1, 2, 3: return enc_r(funct_t'(6'(kind)), rs, rt, rd);
        4:  return enc_i(OP_ADI, rs, rt, imm);
        5:  return enc_i(OP_ORI, rs, rt, imm);
        6:  return enc_i(OP_LHI, rs, rt, imm);
        7:  return enc_i(OP_LWD, rs, rt, imm);
        8:  return enc_i(OP_SWD, rs, rt, imm);
        9:  return enc_i(OP_BEQ, rs, rt, 8'(target - addr - 1));
        10: return enc_i(OP_BNE, rs, rt, 8'(target - addr - 1));
        11: return {OP_JMP, 12'(target)};
        default: return enc_r(FN_WWD, rs, 2'd0, 2'd0);
    endcase
endfunction

task automatic generate_program(int mode);
    int len;
    len  = rand_range(20, 40);
    prog = '{default: HLT_WORD};
    for (int i = 0; i < len - 1; i++)
        prog[PW'(i)] = random_inst(i, len, mode);
endtask

////////////////////
// Reference model, one instruction at a time
task automatic run_model();
    word_t     pc, next, inst, sext, zext, addr;
    opcode_t   op;
    funct_t    fn;
    reg_addr_t rs, rt, rd;
    bit        done;
    pc          = '0;
    done        = 1'b0;
    model_count = 0;
    model_regs  = '{default: '0};
    model_out.delete();
    while (!done && model_count < 2 * PROG_SIZE) begin
        inst = prog[pc[PW-1:0]];
        op   = opcode_t'(inst[15:12]);
        fn   = funct_t'(inst[5:0]);
        rs   = inst[11:10];
        rt   = inst[9:8];
        rd   = inst[7:6];
        sext = {{8{inst[7]}}, inst[7:0]};
        zext = {8'h00, inst[7:0]};
        addr = model_regs[rs] + sext;
        next = pc + 16'd1;
        model_count++;
        case (op)
            OP_ADI: model_regs[rt] = model_regs[rs] + sext;
            OP_ORI: model_regs[rt] = model_regs[rs] | zext;
            OP_LHI: model_regs[rt] = {inst[7:0], 8'h00};
            OP_LWD: model_regs[rt] = model_dmem[addr[AW-1:0]];
            OP_SWD: model_dmem[addr[AW-1:0]] = model_regs[rt];
            OP_BEQ: if (model_regs[rs] == model_regs[rt]) next = next + sext;
            OP_BNE: if (model_regs[rs] != model_regs[rt]) next = next + sext;
            OP_JMP: next = {pc[15:12], inst[11:0]};
            OP_RTYPE: begin
                case (fn)
                    FN_ADD: model_regs[rd] = model_regs[rs] + model_regs[rt];
                    FN_SUB: model_regs[rd] = model_regs[rs] - model_regs[rt];
                    FN_AND: model_regs[rd] = model_regs[rs] & model_regs[rt];
                    FN_ORR: model_regs[rd] = model_regs[rs] | model_regs[rt];
                    FN_WWD: model_out.push_back(model_regs[rs]);
                    FN_HLT: done = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        pc = next;
    end
endtask

// ==== tb/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu;
    import isa_pkg::*;

    localparam int DMEM_DEPTH = 256;
    localparam int AW         = $clog2(DMEM_DEPTH);
    localparam int PROG_SIZE  = 64;
    localparam int PW         = 6;
    localparam int TIMEOUT    = 2000;
    localparam int NUM_TESTS  = 12;

    logic  clk;
    logic  reset_n;
    word_t imem_addr, imem_data, output_port, num_inst;
    logic  output_valid, is_halted;

    word_t dut_out [$];
    int    error_count;
    int    failed_tests;
    int    sva_failures;

    `include "tb_cpu_model.svh"

    cpu_top #(.DMEM_DEPTH(DMEM_DEPTH)) u_dut (
        .clk, .reset_n, .imem_addr, .imem_data,
        .output_port, .output_valid, .num_inst, .is_halted
    );

    // Instruction ROM answers HLT outside the program area
    assign imem_data = (imem_addr[15:PW] == '0) ? prog[imem_addr[PW-1:0]] : HLT_WORD;

    always #4 clk = ~clk;

    task automatic check_value(string what, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", what, expected, actual);
            error_count++;
        end
    endtask

    function automatic string mode_name(int mode);
        case (mode)
            0: return "alu_chain";
            1: return "load_store";
            2: return "branch";
            default: return "mixed";
        endcase
    endfunction

    ////////////////////
    // One random program from reset to halt
    task automatic run_test(int num, int mode);
        string name;
        int    errors_before;
        int    cycles;
        name          = $sformatf("%s_%0d", mode_name(mode), num);
        errors_before = error_count;
        @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        generate_program(mode);      // program swapped while the core sits in reset
        run_model();
        dut_out.delete();
        repeat (4) @(posedge clk);
        reset_n <= 1'b0;
        @(negedge clk);
        check_value({name, " output_valid after reset"}, 16'd0, word_t'(output_valid));
        check_value({name, " is_halted after reset"}, 16'd0, word_t'(is_halted));
        check_value({name, " num_inst after reset"}, 16'd0, num_inst);
        check_value({name, " imem_addr after reset"}, 16'd0, imem_addr);
        cycles = 0;
        while (!is_halted && cycles < TIMEOUT) begin
            @(negedge clk);
            if (output_valid)
                dut_out.push_back(output_port);
            cycles++;
        end
        if (!is_halted) begin
            $display("Test %s timed out, the core did not halt within %0d cycles",
                     name, TIMEOUT);
            error_count++;
        end else begin
            check_value({name, " retired count"}, word_t'(model_count), num_inst);
            check_value({name, " output count"}, word_t'(model_out.size()),
                        word_t'(dut_out.size()));
            for (int k = 0; k < model_out.size() && k < dut_out.size(); k++)
                check_value($sformatf("%s output %0d", name, k), model_out[k], dut_out[k]);
            repeat (20) begin
                @(negedge clk);
                if (output_valid) begin
                    $display("Test %s wrote the output port after halting", name);
                    error_count++;
                end
            end
            check_value({name, " num_inst after halt"}, word_t'(model_count), num_inst);
        end
        if (error_count == errors_before) begin
            $display("Test %s passed, %0d instructions retired, %0d outputs",
                     name, model_count, model_out.size());
        end else begin
            $display("Test %s failed with %0d mismatches", name, error_count - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b1;
        error_count  = 0;
        failed_tests = 0;
        prog         = '{default: HLT_WORD};
        model_dmem   = '{default: '0};
        void'($urandom(15747));
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t, t % 4);
        sva_failures = u_dut.u_sva.failures;
        $display("Tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
                 NUM_TESTS, failed_tests, error_count, sva_failures);
        if (error_count == 0 && sva_failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+tb
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipeline_control.sv
hw/fetch_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
tb/cpu_sva.sv
tb/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build the CPU testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --assert --timescale 1ns/100ps --top-module tb_cpu -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cpu +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -qx "No errors"
if [ $? -ne 0 ]; then
    exit 1
fi
exit 0
